// ==== sources.f ====
src/cpu_pkg.sv
src/axil_pkg.sv
src/sync_fifo.sv
src/axil_read_master.sv
src/branch_predict.sv
src/fetch_unit.sv
test/axil_mem_model.sv
test/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sources.f --top-module fetch_tb --Mdir obj_dir -o fetch_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/fetch_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "PASS: all tests" <<< "$out"; then
	exit 0
fi
exit 1

// ==== test/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_tb
	import cpu_pkg::*;
	import axil_pkg::*;
();

	localparam data_t ECALL_ADDR = 32'h0000_0100;
	localparam data_t BJ_TARGET = 32'h0000_0040;

	logic clk;
	logic rst_n;
	logic go;
	logic stall;
	logic flush;
	data_t pc_bj;
	instr_t instr_w;
	instr_t instr;
	data_t pc_out;
	data_t pc_p4_out;
	logic taken;
	logic instr_valid;
	axil_ar_t ar;
	logic arvalid;
	logic arready;
	axil_r_t r;
	logic rvalid;
	logic rready;

	integer seed = 32'hd497fdd8;
	data_t exp_pc = '0;
	data_t fetch_pc = '0;
	logic read_stale = 1'b0;
	logic halted = 1'b0;
	int r_cnt = 0;
	int got_cnt = 0;
	int n_checks = 0;
	int n_errors = 0;
	int n_timeouts = 0;

	fetch_unit dut0 (
		.clk(clk), .rst_n(rst_n), .go(go), .stall(stall), .flush(flush),
		.pc_bj(pc_bj), .instr_w(instr_w), .instr(instr), .pc_out(pc_out),
		.pc_p4_out(pc_p4_out), .taken(taken), .instr_valid(instr_valid),
		.ar(ar), .arvalid(arvalid), .arready(arready), .r(r), .rvalid(rvalid),
		.rready(rready)
	);

	axil_mem_model mem0 (
		.clk(clk), .rst_n(rst_n), .ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic instr_t swap_bytes(input instr_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// program image as the core should see it
	function automatic instr_t program_word(input data_t a);
		case (a)
			32'h0000_0010: return 32'h0100_006f;
			32'h0000_0018: return 32'hfe00_0ee3;
			32'h0000_001c: return 32'h0000_0463;
			ECALL_ADDR: return ECALL_INSTR;
			default: return {a[15:0] ^ 16'h9e37, a[9:2], 8'h13};
		endcase
	endfunction

	function automatic instr_t mem_word(input data_t a);
		return SWAP_ENDIAN ? swap_bytes(program_word(a)) : program_word(a);
	endfunction

	function automatic instr_t exp_instr(input data_t a);
		return SWAP_ENDIAN ? swap_bytes(mem_word(a)) : mem_word(a);
	endfunction

	// jal or a branch with negative offset
	function automatic logic exp_taken(input instr_t w);
		return (w[6:0] == OPC_JAL) || ((w[6:0] == OPC_BRANCH) && w[31]);
	endfunction

	task automatic check_instr(input string what, input instr_t got, input instr_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input data_t got, input data_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_and_finish();
		$display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
		if (n_errors == 0 && n_timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	task automatic timed_out(input string what, input int limit);
		n_timeouts++;
		$display("Timeout: %s not reached within %0d cycles", what, limit);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_for_pc(input data_t target, input int limit);
		int n;
		n = 0;
		while (exp_pc != target && n < limit) begin
			next_cycle();
			n++;
		end
		if (exp_pc != target) begin
			timed_out($sformatf("delivery up to pc %h", target), limit);
		end
	endtask

	task automatic wait_for_level(input int level, input int limit);
		int n;
		n = 0;
		while ((r_cnt - got_cnt) != level && n < limit) begin
			next_cycle();
			n++;
		end
		if ((r_cnt - got_cnt) != level) begin
			timed_out($sformatf("queue level %0d", level), limit);
		end
	endtask

	// sampled at the falling edge where the outputs are stable
	always @(negedge clk) begin
		if (rst_n) begin
			// address of every read that no flush has made stale
			if (arvalid && arready && !read_stale) begin
				check_addr("ar.addr", ar.addr, fetch_pc);
			end
			if (rvalid && rready) begin
				r_cnt++;
				if (!read_stale && !flush) begin
					fetch_pc = fetch_pc + 32'd4;
				end
				read_stale = 1'b0;
			end
			if (go) begin
				halted = 1'b0;
			end
			if (flush) begin
				exp_pc = pc_bj;
				fetch_pc = pc_bj;
				read_stale = (arvalid || rready) && !(rvalid && rready);
			end
			if (halted) begin
				check_bit("instr_valid after ecall", instr_valid, 1'b0);
				check_bit("arvalid after ecall", arvalid, 1'b0);
				check_bit("rready after ecall", rready, 1'b0);
			end else if (instr_valid) begin
				check_addr("pc_out", pc_out, exp_pc);
				check_addr("pc_p4_out", pc_p4_out, exp_pc + 32'd4);
				check_instr("instr", instr, exp_instr(exp_pc));
				check_bit("taken", taken, exp_taken(exp_instr(exp_pc)));
				if (exp_pc == ECALL_ADDR) begin
					halted = 1'b1;
				end
				exp_pc = exp_pc + 32'd4;
				got_cnt++;
			end
		end
	end

	task automatic run_sequence();
		// nothing moves before go
		repeat (20) begin
			next_cycle();
			check_bit("instr_valid before go", instr_valid, 1'b0);
			check_bit("arvalid before go", arvalid, 1'b0);
			check_bit("rready before go", rready, 1'b0);
		end

		go = 1'b1;
		next_cycle();
		go = 1'b0;
		wait_for_pc(32'h30, 200);
		if (n_timeouts != 0) return;

		// queue fills up to the almost-full mark while decode stalls
		stall = 1'b1;
		repeat (60) next_cycle();
		wait_for_level(QUEUE_ALMOST_FULL, 200);
		if (n_timeouts != 0) return;
		repeat (10) next_cycle();
		check_bit("arvalid at almost full", arvalid, 1'b0);
		check_bit("queue level held", (r_cnt - got_cnt) == QUEUE_ALMOST_FULL, 1'b1);
		stall = 1'b0;
		wait_for_pc(32'h80, 200);
		if (n_timeouts != 0) return;

		// flushes at random points with some reads in flight
		repeat (8) begin
			repeat ($unsigned($random(seed)) % 12) next_cycle();
			flush = 1'b1;
			pc_bj = BJ_TARGET;
			next_cycle();
			flush = 1'b0;
		end
		wait_for_pc(BJ_TARGET + 32'h20, 200);
		if (n_timeouts != 0) return;

		// run into the ecall and stay halted until it retires
		wait_for_pc(ECALL_ADDR + 32'd4, 800);
		if (n_timeouts != 0) return;
		repeat (30) next_cycle();
		instr_w = ECALL_INSTR;
		next_cycle();
		instr_w = '0;
		go = 1'b1;
		next_cycle();
		go = 1'b0;
		wait_for_pc(ECALL_ADDR + 32'h20, 200);
		if (n_timeouts != 0) return;
		repeat (5) next_cycle();
	endtask

	initial begin
		rst_n = 1'b0;
		go = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		pc_bj = '0;
		instr_w = '0;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
		run_sequence();
		report_and_finish();
	end

endmodule : fetch_tb

`default_nettype wire

// ==== test/axil_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module axil_mem_model
	import cpu_pkg::*;
	import axil_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,
	input	axil_ar_t	ar,
	input	logic		arvalid,
	output	logic		arready,
	output	axil_r_t	r,
	output	logic		rvalid,
	input	logic		rready
);

	integer seed = 32'hd497fdd8;
	int delay;
	logic reading;
	data_t addr_q;

	// instruction image, a jal, two branches and an ecall among addi-type filler
	function automatic instr_t program_word(input data_t a);
		case (a)
			32'h0000_0010: return 32'h0100_006f;
			32'h0000_0018: return 32'hfe00_0ee3;
			32'h0000_001c: return 32'h0000_0463;
			32'h0000_0100: return ECALL_INSTR;
			default: return {a[15:0] ^ 16'h9e37, a[9:2], 8'h13};
		endcase
	endfunction

	// bytes stored in the order the fetch swap undoes
	function automatic instr_t word_at(input data_t a);
		instr_t w;
		w = program_word(a);
		return SWAP_ENDIAN ? {w[7:0], w[15:8], w[23:16], w[31:24]} : w;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			r <= '0;
			delay <= 0;
			reading <= 1'b0;
			addr_q <= '0;
		end else if (!reading) begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				addr_q <= ar.addr;
				reading <= 1'b1;
				delay <= $unsigned($random(seed)) % 4;
			end else if (arvalid) begin
				// random wait before accepting the address
				if (delay == 0) begin
					arready <= 1'b1;
				end else begin
					delay <= delay - 1;
				end
			end
		end else begin
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				reading <= 1'b0;
				delay <= $unsigned($random(seed)) % 4;
			end else if (!rvalid) begin
				if (delay == 0) begin
					rvalid <= 1'b1;
					r <= '{data: word_at(addr_q), resp: AXIL_RESP_OKAY};
				end else begin
					delay <= delay - 1;
				end
			end
		end
	end

endmodule : axil_mem_model

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
	import cpu_pkg::*;
	import axil_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,

	// core control
	input	logic		go,
	input	logic		stall,
	input	logic		flush,
	input	data_t		pc_bj,
	input	instr_t		instr_w,

	// to decode
	output	instr_t		instr,
	output	data_t		pc_out,
	output	data_t		pc_p4_out,
	output	logic		taken,
	output	logic		instr_valid,

	// AXI-Lite read master
	output	axil_ar_t	ar,
	output	logic		arvalid,
	input	logic		arready,
	input	axil_r_t	r,
	input	logic		rvalid,
	output	logic		rready
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_STALL,
		ST_HALT
	} state_t;

	state_t state;
	state_t state_nxt;

	data_t pc;
	logic discard;

	logic rd_req;
	data_t rd_data;
	logic done;
	logic busy;

	logic push;
	logic push_ecall;
	fetch_entry_t push_entry;
	fetch_entry_t head;
	logic q_empty;
	logic q_full;
	logic q_almost_full;
	logic [QUEUE_CNT_W-1:0] q_count;

	function automatic instr_t order_bytes(input instr_t w);
		if (SWAP_ENDIAN) begin
			return {w[7:0], w[15:8], w[23:16], w[31:24]};
		end else begin
			return w;
		end
	endfunction

	// stale responses and responses racing a flush never enter the queue
	assign push = done && !discard && !flush;
	assign push_ecall = (order_bytes(rd_data) == ECALL_INSTR);
	assign push_entry = '{instr: rd_data, pc: pc};

	// one read at a time, only with room left in the queue
	assign rd_req = (state == ST_FETCH) && !busy && !flush &&
		(q_count < QUEUE_CNT_W'(QUEUE_ALMOST_FULL));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (flush) begin
			pc <= pc_bj;
		end else if (push) begin
			pc <= pc + data_t'(4);
		end
	end

	// mark the read in flight as stale after a flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			discard <= 1'b0;
		end else if (flush && busy && !done) begin
			discard <= 1'b1;
		end else if (done) begin
			discard <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: if (go) state_nxt = ST_FETCH;
			ST_FETCH, ST_STALL: begin
				if (push && push_ecall) begin
					state_nxt = ST_HALT;
				end else if (q_almost_full) begin
					state_nxt = ST_STALL;
				end else begin
					state_nxt = ST_FETCH;
				end
			end
			// wait for the core to retire the ecall
			ST_HALT: if (instr_w == ECALL_INSTR) state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	// head is killed in a flush cycle
	assign instr_valid = !q_empty && !stall && !flush;

	assign instr = order_bytes(head.instr);
	assign pc_out = head.pc;
	assign pc_p4_out = head.pc + data_t'(4);

	axil_read_master rd_master0 (
		.clk		(clk),
		.rst_n		(rst_n),
		.rd_req		(rd_req),
		.req_addr	(pc),
		.rd_data	(rd_data),
		.done		(done),
		.busy		(busy),
		.ar			(ar),
		.arvalid	(arvalid),
		.arready	(arready),
		.r			(r),
		.rvalid		(rvalid),
		.rready		(rready)
	);

	sync_fifo #(
		.T			(fetch_entry_t),
		.DEPTH		(QUEUE_DEPTH)
	) instr_queue0 (
		.clk			(clk),
		.rst_n			(rst_n),
		.clear			(flush),
		.wr_en			(push),
		.wr_data		(push_entry),
		.rd_en			(instr_valid),
		.rd_data		(head),
		.empty			(q_empty),
		.full			(q_full),
		.almost_full	(q_almost_full),
		.count			(q_count)
	);

	branch_predict predict0 (
		.instr	(instr),
		.taken	(taken)
	);

	a_go_flush: assert property (@(posedge clk) disable iff (!rst_n) !(flush && go));
	// request pacing keeps the queue from ever filling
	a_never_full: assert property (@(posedge clk) disable iff (!rst_n) !q_full);
	// a pushed word belongs to the address the master put on AR
	a_push_addr: assert property (@(posedge clk) disable iff (!rst_n) push |-> ar.addr == pc);

endmodule : fetch_unit

`default_nettype wire

// ==== src/branch_predict.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predict
	import cpu_pkg::*;
(
	input	instr_t		instr,
	output	logic		taken
);

	logic [6:0] opcode;
	logic is_jal;
	logic is_back_branch;

	assign opcode = instr[6:0];

	// unconditional jump always predicted taken
	assign is_jal = (opcode == OPC_JAL);

	// sign bit of the B-type offset, backward loops taken
	assign is_back_branch = (opcode == OPC_BRANCH) && instr[31];

	assign taken = is_jal || is_back_branch;

endmodule : branch_predict

`default_nettype wire

// ==== src/axil_read_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module axil_read_master
	import cpu_pkg::*;
	import axil_pkg::*;
(
	input	logic		clk,
	input	logic		rst_n,

	// request side
	input	logic		rd_req,
	input	data_t		req_addr,
	output	data_t		rd_data,
	output	logic		done,
	output	logic		busy,

	// AXI-Lite read channels
	output	axil_ar_t	ar,
	output	logic		arvalid,
	input	logic		arready,
	input	axil_r_t	r,
	input	logic		rvalid,
	output	logic		rready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ADDR,
		S_DATA
	} state_t;

	state_t state;
	data_t addr_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (rd_req) state <= S_ADDR;
				S_ADDR: if (arready) state <= S_DATA;
				S_DATA: if (rvalid) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// address held for the whole AR phase
	always_ff @(posedge clk) begin
		if (rd_req && (state == S_IDLE)) begin
			addr_q <= req_addr;
		end
	end

	assign ar = '{addr: addr_q, prot: AXIL_PROT_INSTR};
	assign arvalid = (state == S_ADDR);
	assign rready = (state == S_DATA);

	assign busy = (state != S_IDLE);
	// done coincides with the R handshake
	assign done = (state == S_DATA) && rvalid;
	assign rd_data = r.data;

	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(ar));
	a_req_idle: assert property (@(posedge clk) disable iff (!rst_n) rd_req |-> !busy);
	a_resp_okay: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && rready |-> r.resp == AXIL_RESP_OKAY);

endmodule : axil_read_master

`default_nettype wire

// ==== src/sync_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sync_fifo
	import cpu_pkg::*;
#(
	parameter type T = logic [31:0],
	parameter int DEPTH = QUEUE_DEPTH
) (
	input	logic						clk,
	input	logic						rst_n,
	input	logic						clear,
	input	logic						wr_en,
	input	T							wr_data,
	input	logic						rd_en,
	output	T							rd_data,
	output	logic						empty,
	output	logic						full,
	output	logic						almost_full,
	output	logic [$clog2(DEPTH+1)-1:0]	count
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	T mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// head entry shown straight from storage
	assign rd_data = mem[rd_ptr];

	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));
	assign almost_full = (count >= CW'(QUEUE_ALMOST_FULL));

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop keep the level
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty);
	a_clear_alone: assert property (@(posedge clk) disable iff (!rst_n)
		clear |-> !wr_en && !rd_en);

endmodule : sync_fifo

`default_nettype wire

// ==== src/axil_pkg.sv ====
`default_nettype none

package axil_pkg;

	import cpu_pkg::*;

	// read address channel payload
	typedef struct packed {
		data_t addr;
		logic [2:0] prot;
	} axil_ar_t;

	// read data channel payload
	typedef struct packed {
		data_t data;
		logic [1:0] resp;
	} axil_r_t;

	// response code for a good read
	localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

	// unprivileged, secure, instruction access
	localparam logic [2:0] AXIL_PROT_INSTR = 3'b100;

endpackage : axil_pkg

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// datapath width
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [31:0] instr_t;

	// system call encoding, funct12 and rs1/rd all zero
	localparam instr_t ECALL_INSTR = 32'h0000_0073;

	// major opcodes used by the static predictor
	localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
	localparam logic [6:0] OPC_JAL = 7'b110_1111;

	// instruction queue sizing
	localparam int QUEUE_DEPTH = 16;
	// two slots kept free for the read still in flight
	localparam int QUEUE_ALMOST_FULL = 14;
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

	// 1 reverses the bytes of each instruction word from memory
	localparam logic SWAP_ENDIAN = 1'b0;

	// one queue slot: fetched word and the address it came from
	typedef struct packed {
		instr_t instr;
		data_t pc;
	} fetch_entry_t;

endpackage : cpu_pkg

`default_nettype wire
